//--- Bender.yml
package:
  name: simd_mul

sources:
  - hdl/simd_mul_pkg.sv
  - hdl/booth_pp_row.sv
  - hdl/booth_decode.sv
  - hdl/pp_reduce.sv
  - hdl/lane_result.sv
  - hdl/mul_wb_regs.sv
  - hdl/simd_mul_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/simd_mul_tb.sv

//--- bench/simd_mul_model.svh
`ifndef SIMD_MUL_MODEL_SVH
`define SIMD_MUL_MODEL_SVH

// value of one lane slice, read as signed or unsigned.
function automatic longint lane_value(input logic [simd_mul_pkg::data_w-1:0] word,
                                      input int lsb,
                                      input int w,
                                      input logic sgn);
   longint v;
   v = 0;
   for (int i = 0; i < w; i++) begin
      v[i] = word[lsb + i];
   end
   if (sgn && word[lsb + w - 1]) begin
      v = v - (longint'(1) << w);
   end
   return v;
endfunction

// exact lane products, lane 0 in the lowest field.
function automatic logic [simd_mul_pkg::result_w-1:0] expected_result(
   input logic [simd_mul_pkg::data_w-1:0] a,
   input logic [simd_mul_pkg::data_w-1:0] b,
   input logic quad,
   input logic sgn
);
   int                                w;
   int                                lanes;
   longint                            p;
   logic [simd_mul_pkg::result_w-1:0] res;
   w = quad ? simd_mul_pkg::quad_lane_w : simd_mul_pkg::dual_lane_w;
   lanes = simd_mul_pkg::data_w / w;
   res = '0;
   for (int l = 0; l < lanes; l++) begin
      p = lane_value(a, l*w, w, sgn) * lane_value(b, l*w, w, sgn);
      for (int i = 0; i < 2*w; i++) begin
         res[l*2*w + i] = p[i];
      end
   end
   return res;
endfunction

function automatic logic [simd_mul_pkg::data_w-1:0] command_word(input logic quad,
                                                                 input logic sgn);
   logic [simd_mul_pkg::data_w-1:0] w;
   w = '0;
   w[simd_mul_pkg::cmd_quad_bit] = quad;
   w[simd_mul_pkg::cmd_signed_bit] = sgn;
   return w;
endfunction

`endif

//--- bench/simd_mul_tb.sv
`timescale 1ns/100ps
`default_nettype none

module simd_mul_tb;

   logic                            clk;
   logic                            rst;
   logic                            cyc;
   logic                            stb;
   logic                            we;
   logic [simd_mul_pkg::adr_w-1:0]  adr;
   logic [simd_mul_pkg::data_w-1:0] dat_w;
   logic [simd_mul_pkg::data_w-1:0] dat_r;
   logic                            ack;

   `include "simd_mul_model.svh"

   simd_mul_top simd_mul_top_i (
      .clk(clk),
      .rst(rst),
      .cyc(cyc),
      .stb(stb),
      .we(we),
      .adr(adr),
      .dat_w(dat_w),
      .dat_r(dat_r),
      .ack(ack)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #50 clk = ~clk;
      end
   end

   task automatic stop_on_timeout(input string what);
      $display("timeout: no Wishbone ack for %s within 20 cycles", what);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("ERROR at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
         $display("Regression failed");
         $fatal(1);
      end
   endtask

   // called and left on a falling edge.
   task automatic write_reg(input logic [simd_mul_pkg::adr_w-1:0] a, input logic [31:0] d);
      int n;
      cyc = 1'b1;
      stb = 1'b1;
      we = 1'b1;
      adr = a;
      dat_w = d;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!ack && n < 20);
      if (!ack) begin
         stop_on_timeout("register write");
      end else begin
         cyc = 1'b0;
         stb = 1'b0;
         we = 1'b0;
      end
   endtask

   task automatic read_reg(input logic [simd_mul_pkg::adr_w-1:0] a, output logic [31:0] d,
                           output int waited);
      int n;
      cyc = 1'b1;
      stb = 1'b1;
      we = 1'b0;
      adr = a;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!ack && n < 20);
      if (!ack) begin
         stop_on_timeout("register read");
      end else begin
         d = dat_r;
         waited = n;
         cyc = 1'b0;
         stb = 1'b0;
      end
   endtask

   // corner operands for both lane widths.
   function automatic logic [31:0] edge_operand(input int idx);
      case (idx)
         0:       return 32'h8000_8000;
         1:       return 32'hffff_ffff;
         2:       return 32'h7fff_7fff;
         3:       return 32'h0000_0000;
         4:       return 32'h8080_8080;
         default: return 32'h807f_ff01;
      endcase
   endfunction

   task automatic check_result(input logic [63:0] exp, output int waited);
      logic [31:0] lo;
      logic [31:0] hi;
      int          n;
      read_reg(simd_mul_pkg::addr_res_lo, lo, waited);
      read_reg(simd_mul_pkg::addr_res_hi, hi, n);
      check_word("res_lo", exp[31:0], lo);
      check_word("res_hi", exp[63:32], hi);
   endtask

   task automatic run_command(input logic [31:0] a, input logic [31:0] b, input logic q,
                              input logic sg, output int waited);
      write_reg(simd_mul_pkg::addr_op_a, a);
      write_reg(simd_mul_pkg::addr_op_b, b);
      write_reg(simd_mul_pkg::addr_cmd, command_word(q, sg));
      check_result(expected_result(a, b, q, sg), waited);
   endtask

   initial begin
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] word;
      logic        q;
      logic        sg;
      int          waited;
      void'($urandom(32'he6a0));
      rst = 1'b1;
      cyc = 1'b0;
      stb = 1'b0;
      we = 1'b0;
      adr = '0;
      dat_w = '0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      check_result(64'd0, waited);

      a = $urandom();
      b = $urandom();
      write_reg(simd_mul_pkg::addr_op_a, a);
      write_reg(simd_mul_pkg::addr_op_b, b);
      write_reg(simd_mul_pkg::addr_cmd, command_word(1'b1, 1'b1));
      read_reg(simd_mul_pkg::addr_op_a, word, waited);
      check_word("op_a", a, word);
      read_reg(simd_mul_pkg::addr_op_b, word, waited);
      check_word("op_b", b, word);
      read_reg(simd_mul_pkg::addr_cmd, word, waited);
      check_word("cmd", command_word(1'b1, 1'b1), word);

      // dual lanes first, then quad lanes.
      for (int m = 0; m < 2; m++) begin
         for (int i = 0; i < 200; i++) begin
            if (i < 72) begin
               a = edge_operand(i % 6);
               b = edge_operand((i / 6) % 6);
               sg = (i >= 36);
            end else begin
               a = $urandom();
               b = $urandom();
               sg = 1'($urandom() % 2);
            end
            run_command(a, b, (m == 1), sg, waited);
         end
      end

      // result read issued right after the command ack must be held off.
      // done comes two clocks after the command ack, so the read ack needs three.
      for (int i = 0; i < 20; i++) begin
         a = $urandom();
         b = $urandom();
         q = 1'($urandom() % 2);
         sg = 1'($urandom() % 2);
         run_command(a, b, q, sg, waited);
         assert (waited >= 3) else begin
            $display("result read right after a command was acked before the result was ready");
            $display("Regression failed");
            $fatal(1);
         end
      end

      // two commands in a row, the second one's product is read.
      for (int i = 0; i < 20; i++) begin
         a = $urandom();
         b = $urandom();
         q = 1'($urandom() % 2);
         sg = 1'($urandom() % 2);
         write_reg(simd_mul_pkg::addr_op_a, a);
         write_reg(simd_mul_pkg::addr_op_b, b);
         write_reg(simd_mul_pkg::addr_cmd, command_word(~q, ~sg));
         write_reg(simd_mul_pkg::addr_cmd, command_word(q, sg));
         check_result(expected_result(a, b, q, sg), waited);
      end

      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+bench
hdl/simd_mul_pkg.sv
hdl/booth_pp_row.sv
hdl/booth_decode.sv
hdl/pp_reduce.sv
hdl/lane_result.sv
hdl/mul_wb_regs.sv
hdl/simd_mul_top.sv
bench/simd_mul_tb.sv

//--- hdl/booth_decode.sv
`timescale 1ns/100ps
`default_nettype none

module booth_decode (
   input  logic [simd_mul_pkg::data_w-1:0]                         op_a,
   input  logic                                                    quad,
   input  logic                                                    is_signed,
   output logic [simd_mul_pkg::max_digits*simd_mul_pkg::digit_w-1:0] digits
);

   // overlapping triple {b(2k+1), b(2k), b(2k-1)} to a digit in -2..2.
   function automatic logic [simd_mul_pkg::digit_w-1:0] recode(input logic [2:0] t);
      logic [simd_mul_pkg::digit_w-1:0] d;
      d = '0;
      d[simd_mul_pkg::digit_nz_bit] = (t != 3'b000) && (t != 3'b111);
      d[simd_mul_pkg::digit_dbl_bit] = (t == 3'b011) || (t == 3'b100);
      d[simd_mul_pkg::digit_neg_bit] = t[2] && (t != 3'b111);
      return d;
   endfunction

   // index 0 builds the dual layout, index 1 the quad layout.
   for (genvar m = 0; m < 2; m++) begin : g_mode
      localparam int lane_w = (m == 1) ? simd_mul_pkg::quad_lane_w : simd_mul_pkg::dual_lane_w;
      localparam int lanes = simd_mul_pkg::data_w / lane_w;
      localparam int nd = (m == 1) ? simd_mul_pkg::quad_digits : simd_mul_pkg::dual_digits;

      logic [simd_mul_pkg::max_digits*simd_mul_pkg::digit_w-1:0] slots;

      for (genvar l = 0; l < lanes; l++) begin : g_lane
         logic          ext;
         logic [2*nd:0] vec;

         assign ext = is_signed & op_a[l*lane_w + lane_w - 1];
         // the bit below each lane is cut to zero so lanes do not interact.
         assign vec = {{(2*nd - lane_w){ext}}, op_a[l*lane_w +: lane_w], 1'b0};

         for (genvar k = 0; k < nd; k++) begin : g_digit
            assign slots[(l*nd + k)*simd_mul_pkg::digit_w +: simd_mul_pkg::digit_w] =
               recode(vec[2*k +: 3]);
         end
      end

      if (lanes*nd < simd_mul_pkg::max_digits) begin : g_pad
         assign slots[simd_mul_pkg::max_digits*simd_mul_pkg::digit_w-1:
                      lanes*nd*simd_mul_pkg::digit_w] = '0;
      end
   end

   always_comb begin
      case (quad)
         simd_mul_pkg::mode_dual: digits = g_mode[0].slots;
         simd_mul_pkg::mode_quad: digits = g_mode[1].slots;
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/booth_pp_row.sv
`timescale 1ns/100ps
`default_nettype none

module booth_pp_row #(
   parameter int row_w = 16
) (
   input  logic [simd_mul_pkg::digit_w-1:0] digit,
   input  logic [row_w-1:0]                 mcand,
   input  logic                             is_signed,
   output logic [row_w+1:0]                 row
);

   logic             sgn;
   logic [row_w+1:0] ext;
   logic [row_w+1:0] mag;
   logic             neg;

   // multiplicand widened by two bits, by sign or by zero.
   assign sgn = is_signed & mcand[row_w-1];
   assign ext = {{2{sgn}}, mcand};

   always_comb begin
      if (!digit[simd_mul_pkg::digit_nz_bit]) begin
         mag = '0;
      end else if (digit[simd_mul_pkg::digit_dbl_bit]) begin
         mag = {ext[row_w:0], 1'b0};
      end else begin
         mag = ext;
      end
   end

   // negative digits invert and add the carry-in here.
   assign neg = digit[simd_mul_pkg::digit_neg_bit];
   assign row = neg ? (~mag + {{(row_w+1){1'b0}}, 1'b1}) : mag;

endmodule

`default_nettype wire

//--- hdl/lane_result.sv
`timescale 1ns/100ps
`default_nettype none

module lane_result (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [simd_mul_pkg::result_w-1:0] lane_sums,
   input  logic                              valid,
   output logic [simd_mul_pkg::result_w-1:0] result,
   output logic                              done
);

   // lane 0 already sits in the low bits of lane_sums.
   always_ff @(posedge clk) begin
      if (rst) begin
         result <= '0;
         done <= 1'b0;
      end else begin
         done <= valid;
         if (valid) begin
            result <= lane_sums;
         end
      end
   end

   // done follows valid by one cycle.
   a_done_after_valid : assert property (@(posedge clk) disable iff (rst)
      done |-> $past(valid));

endmodule

`default_nettype wire

//--- hdl/mul_wb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module mul_wb_regs (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                cyc,
   input  logic                                stb,
   input  logic                                we,
   input  logic [simd_mul_pkg::adr_w-1:0]      adr,
   input  logic [simd_mul_pkg::data_w-1:0]     dat_w,
   output logic [simd_mul_pkg::data_w-1:0]     dat_r,
   output logic                                ack,
   input  logic [simd_mul_pkg::result_w-1:0]   result,
   input  logic                                done,
   output logic [simd_mul_pkg::data_w-1:0]     op_a,
   output logic [simd_mul_pkg::data_w-1:0]     op_b,
   output logic                                quad,
   output logic                                is_signed,
   output logic                                start
);

   logic                              req;
   logic                              res_rd;
   logic                              ready;
   logic                              take;
   logic                              cmd_wr;
   logic [1:0]                        inflight;
   logic [simd_mul_pkg::data_w-1:0]   cmd_word;
   logic [simd_mul_pkg::data_w-1:0]   rd_word;

   // a new request is one that has not been acked yet.
   assign req = cyc & stb & ~ack;
   assign res_rd = ~we & ((adr == simd_mul_pkg::addr_res_lo) |
                          (adr == simd_mul_pkg::addr_res_hi));

   // result is current once the only command left is the one finishing now.
   assign ready = (inflight == {1'b0, done});
   assign take = req & (~res_rd | ready);
   assign cmd_wr = take & we & (adr == simd_mul_pkg::addr_cmd);

   always_comb begin
      cmd_word = '0;
      cmd_word[simd_mul_pkg::cmd_quad_bit] = quad;
      cmd_word[simd_mul_pkg::cmd_signed_bit] = is_signed;
   end

   always_comb begin
      case (adr)
         simd_mul_pkg::addr_op_a:   rd_word = op_a;
         simd_mul_pkg::addr_op_b:   rd_word = op_b;
         simd_mul_pkg::addr_cmd:    rd_word = cmd_word;
         simd_mul_pkg::addr_res_lo: rd_word = result[simd_mul_pkg::data_w-1:0];
         simd_mul_pkg::addr_res_hi: rd_word = result[simd_mul_pkg::result_w-1:simd_mul_pkg::data_w];
         default:                   rd_word = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ack <= 1'b0;
         start <= 1'b0;
         dat_r <= '0;
         op_a <= '0;
         op_b <= '0;
         quad <= 1'b0;
         is_signed <= 1'b0;
         inflight <= '0;
      end else begin
         ack <= take;
         start <= cmd_wr;
         if (take && !we) begin
            dat_r <= rd_word;
         end
         if (take && we) begin
            case (adr)
               simd_mul_pkg::addr_op_a: op_a <= dat_w;
               simd_mul_pkg::addr_op_b: op_b <= dat_w;
               simd_mul_pkg::addr_cmd: begin
                  quad <= dat_w[simd_mul_pkg::cmd_quad_bit];
                  is_signed <= dat_w[simd_mul_pkg::cmd_signed_bit];
               end
               default: ;
            endcase
         end
         case ({cmd_wr, done})
            2'b10:   inflight <= inflight + 2'd1;
            2'b01:   inflight <= inflight - 2'd1;
            default: ;
         endcase
      end
   end

   // every ack answers a strobe seen on the bus.
   a_ack_needs_stb : assert property (@(posedge clk) disable iff (rst)
      $rose(ack) |-> $past(cyc & stb));

endmodule

`default_nettype wire

//--- hdl/pp_reduce.sv
`timescale 1ns/100ps
`default_nettype none

module pp_reduce (
   input  logic                                                    clk,
   input  logic                                                    rst,
   input  logic [simd_mul_pkg::data_w-1:0]                         op_b,
   input  logic [simd_mul_pkg::max_digits*simd_mul_pkg::digit_w-1:0] digits,
   input  logic                                                    quad,
   input  logic                                                    is_signed,
   input  logic                                                    start,
   output logic [simd_mul_pkg::result_w-1:0]                       lane_sums,
   output logic                                                    valid
);

   // index 0 builds the dual lanes, index 1 the quad lanes.
   for (genvar m = 0; m < 2; m++) begin : g_mode
      localparam int lane_w = (m == 1) ? simd_mul_pkg::quad_lane_w : simd_mul_pkg::dual_lane_w;
      localparam int lanes = simd_mul_pkg::data_w / lane_w;
      localparam int nd = (m == 1) ? simd_mul_pkg::quad_digits : simd_mul_pkg::dual_digits;
      localparam int sum_w = 2*lane_w;

      logic [simd_mul_pkg::result_w-1:0] fields;

      for (genvar l = 0; l < lanes; l++) begin : g_lane
         logic [lane_w+1:0] rows [nd];
         logic [sum_w-1:0]  sum;

         for (genvar k = 0; k < nd; k++) begin : g_row
            booth_pp_row #(
               .row_w(lane_w)
            ) row_i (
               .digit(digits[(l*nd + k)*simd_mul_pkg::digit_w +: simd_mul_pkg::digit_w]),
               .mcand(op_b[l*lane_w +: lane_w]),
               .is_signed(is_signed),
               .row(rows[k])
            );
         end

         // rows are two's complement, so sign extend and weight by 4^k.
         always_comb begin
            sum = '0;
            for (int k = 0; k < nd; k++) begin
               sum = sum + (sum_w'(signed'(rows[k])) << (2*k));
            end
         end

         assign fields[l*sum_w +: sum_w] = sum;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         valid <= 1'b0;
      end else begin
         valid <= start;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         case (quad)
            simd_mul_pkg::mode_dual: lane_sums <= g_mode[0].fields;
            simd_mul_pkg::mode_quad: lane_sums <= g_mode[1].fields;
         endcase
      end
   end

   // a new command must not change the mode under the registered sums.
   a_quad_stable : assert property (@(posedge clk) disable iff (rst)
      valid |-> $stable(quad));

endmodule

`default_nettype wire

//--- hdl/simd_mul_pkg.sv
`default_nettype none

package simd_mul_pkg;

   // bus and datapath widths.
   localparam int data_w = 32;
   localparam int result_w = 64;
   localparam int adr_w = 3;

   // lane widths per mode.
   localparam int dual_lane_w = 16;
   localparam int quad_lane_w = 8;

   // radix-4 digits per lane, after one bit of extension.
   localparam int dual_digits = 9;
   localparam int quad_digits = 5;
   localparam int max_digits = 20;

   // digit encoding: {negate, double, nonzero}.
   localparam int digit_w = 3;
   localparam int digit_neg_bit = 2;
   localparam int digit_dbl_bit = 1;
   localparam int digit_nz_bit = 0;

   // register word addresses.
   localparam logic [adr_w-1:0] addr_op_a = 3'd0;
   localparam logic [adr_w-1:0] addr_op_b = 3'd1;
   localparam logic [adr_w-1:0] addr_cmd = 3'd2;
   localparam logic [adr_w-1:0] addr_res_lo = 3'd3;
   localparam logic [adr_w-1:0] addr_res_hi = 3'd4;

   // command word fields.
   localparam int cmd_quad_bit = 0;
   localparam int cmd_signed_bit = 1;

   // lane mode encoding, as held in the quad flag.
   localparam logic mode_dual = 1'b0;
   localparam logic mode_quad = 1'b1;

endpackage

`default_nettype wire

//--- hdl/simd_mul_top.sv
`timescale 1ns/100ps
`default_nettype none

module simd_mul_top (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            cyc,
   input  logic                            stb,
   input  logic                            we,
   input  logic [simd_mul_pkg::adr_w-1:0]  adr,
   input  logic [simd_mul_pkg::data_w-1:0] dat_w,
   output logic [simd_mul_pkg::data_w-1:0] dat_r,
   output logic                            ack
);

   logic [simd_mul_pkg::data_w-1:0]                          op_a;
   logic [simd_mul_pkg::data_w-1:0]                          op_b;
   logic                                                     quad;
   logic                                                     is_signed;
   logic                                                     start;
   logic [simd_mul_pkg::max_digits*simd_mul_pkg::digit_w-1:0] digits;
   logic [simd_mul_pkg::result_w-1:0]                        lane_sums;
   logic                                                     valid;
   logic [simd_mul_pkg::result_w-1:0]                        result;
   logic                                                     done;

   mul_wb_regs mul_wb_regs_i (
      .clk(clk),
      .rst(rst),
      .cyc(cyc),
      .stb(stb),
      .we(we),
      .adr(adr),
      .dat_w(dat_w),
      .dat_r(dat_r),
      .ack(ack),
      .result(result),
      .done(done),
      .op_a(op_a),
      .op_b(op_b),
      .quad(quad),
      .is_signed(is_signed),
      .start(start)
   );

   booth_decode booth_decode_i (
      .op_a(op_a),
      .quad(quad),
      .is_signed(is_signed),
      .digits(digits)
   );

   pp_reduce pp_reduce_i (
      .clk(clk),
      .rst(rst),
      .op_b(op_b),
      .digits(digits),
      .quad(quad),
      .is_signed(is_signed),
      .start(start),
      .lane_sums(lane_sums),
      .valid(valid)
   );

   lane_result lane_result_i (
      .clk(clk),
      .rst(rst),
      .lane_sums(lane_sums),
      .valid(valid),
      .result(result),
      .done(done)
   );

endmodule

`default_nettype wire
